// ==== list.f ====
+incdir+rtl
+incdir+sim
rtl/cmp_pkg.sv
rtl/cmp_channel_slot.sv
rtl/cmp_write_ctrl.sv
rtl/cmp_progress_tracker.sv
rtl/cmp_irq_merge.sv
rtl/cmp_mgr_top.sv
sim/cmp_mgr_props.sv
sim/cmp_mgr_tb.sv

// ==== rtl/cmp_channel_slot.sv ====
/* channel completion slot
   grants one engine report while empty and holds its record until written */
`timescale 1ns/1ps
`default_nettype none
`include "cmp_settings.svh"

module cmp_channel_slot (
    input  logic                                    clk,
    input  logic                                    resetn,
    input  logic [`CMP_ENGINES-1:0]                 eng_done,
    input  cmp_pkg::cmp_record_u [`CMP_ENGINES-1:0] eng_data,
    input  logic                                    wr_accept,
    output logic [`CMP_ENGINES-1:0]                 eng_okay,
    output logic                                    pending,
    output cmp_pkg::cmp_record_u                    record,
    output logic                                    irq_pulse
);
    import cmp_pkg::*;

    localparam int ENGINES = `CMP_ENGINES;

    logic        grant;
    cmp_record_u grant_data;

    // lowest requesting engine, only while the slot is empty
    assign eng_okay = pending ? '0 : (eng_done & (~eng_done + ENGINES'(1)));
    assign grant    = |eng_okay;

    always_comb begin
        grant_data = '0;
        for (int e = 0; e < ENGINES; e++) begin
            if (eng_okay[e]) begin
                grant_data = eng_data[e];
            end
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            pending <= 1'b0;
        end else if (grant) begin
            pending <= 1'b1;
        end else if (wr_accept) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            record <= grant_data;
        end
    end

    // one pulse per flagged record
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            irq_pulse <= 1'b0;
        end else begin
            irq_pulse <= grant & grant_data.fields.irq_flag;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cmp_irq_merge.sv ====
/* interrupt merger
   serves channel interrupt requests and action interrupts over one host interrupt */
`timescale 1ns/1ps
`default_nettype none
`include "cmp_settings.svh"

module cmp_irq_merge (
    input  logic                                        clk,
    input  logic                                        resetn,
    input  logic [`CMP_CHANNELS-1:0]                    irq_pulse,
    input  cmp_pkg::cmp_chan_cfg_t [`CMP_CHANNELS-1:0]  chan_cfg,
    input  logic                                        action_interrupt,
    input  cmp_pkg::cmp_irq_t                           action_irq,
    input  logic                                        odma_interrupt_ack,
    output logic                                        odma_interrupt,
    output cmp_pkg::cmp_irq_t                           odma_irq,
    output logic                                        action_interrupt_ack
);
    import cmp_pkg::*;

    localparam int CHANNELS = `CMP_CHANNELS;
    localparam int CHAN_W   = `CMP_CHAN_W;

    logic [CHANNELS-1:0] chan_req;
    logic [CHAN_W-1:0]   irq_chan;
    logic                serving_action;
    logic                chan_ack;

    // ack goes to whichever source owns the interrupt
    assign chan_ack             = odma_interrupt & odma_interrupt_ack & ~serving_action;
    assign action_interrupt_ack = odma_interrupt & odma_interrupt_ack & serving_action;

    // a new flagged record wins over the clear of the served request
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            chan_req <= '0;
        end else begin
            for (int c = 0; c < CHANNELS; c++) begin
                if (irq_pulse[c]) begin
                    chan_req[c] <= 1'b1;
                end else if (chan_ack && (irq_chan == CHAN_W'(c))) begin
                    chan_req[c] <= 1'b0;
                end
            end
        end
    end

    // channels before the action, source fixed while served
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            odma_interrupt <= 1'b0;
            serving_action <= 1'b0;
            irq_chan       <= '0;
        end else if (odma_interrupt) begin
            if (odma_interrupt_ack) begin
                odma_interrupt <= 1'b0;
            end
        end else if (|chan_req) begin
            odma_interrupt <= 1'b1;
            serving_action <= 1'b0;
            irq_chan       <= cmp_lowest_chan(chan_req);
        end else if (action_interrupt) begin
            odma_interrupt <= 1'b1;
            serving_action <= 1'b1;
        end
    end

    assign odma_irq.ctx = serving_action ? action_irq.ctx : '0;
    assign odma_irq.src = serving_action ? action_irq.src : chan_cfg[irq_chan].obj_handle;

endmodule

`default_nettype wire

// ==== rtl/cmp_mgr_top.sv ====
/* completion manager top
   channel slots, write controller, progress tracker and interrupt merger */
`timescale 1ns/1ps
`default_nettype none
`include "cmp_settings.svh"

module cmp_mgr_top (
    input  logic                                                    clk,
    input  logic                                                    resetn,
    // engines, indexed [engine][channel]
    input  logic [`CMP_ENGINES-1:0][`CMP_CHANNELS-1:0]              eng_cmp_done,
    input  cmp_pkg::cmp_record_u [`CMP_ENGINES-1:0][`CMP_CHANNELS-1:0] eng_cmp_data,
    output logic [`CMP_ENGINES-1:0][`CMP_CHANNELS-1:0]              eng_cmp_okay,
    // channel configuration and descriptor side
    input  cmp_pkg::cmp_chan_cfg_t [`CMP_CHANNELS-1:0]              chan_cfg,
    input  logic                                                    manager_start,
    input  logic [`CMP_CHANNELS-1:0]                                channel_done,
    output logic [`CMP_CHANNELS-1:0]                                completion_done,
    // local write
    output logic                                                    lcl_wr_valid,
    output cmp_pkg::cmp_write_req_t                                 lcl_wr,
    input  logic                                                    lcl_wr_ready,
    // interrupts
    input  logic                                                    action_interrupt,
    input  cmp_pkg::cmp_irq_t                                       action_irq,
    output logic                                                    action_interrupt_ack,
    output logic                                                    odma_interrupt,
    output cmp_pkg::cmp_irq_t                                       odma_irq,
    input  logic                                                    odma_interrupt_ack
);
    import cmp_pkg::*;

    logic [`CMP_CHANNELS-1:0]                   slot_pending;
    cmp_record_u [`CMP_CHANNELS-1:0]            slot_record;
    logic [`CMP_CHANNELS-1:0]                   slot_irq_pulse;
    logic [`CMP_CHANNELS-1:0]                   wr_accept;
    logic [`CMP_CHANNELS-1:0][`CMP_COUNT_W-1:0] counts;

    for (genvar c = 0; c < `CMP_CHANNELS; c++) begin : g_chan
        logic [`CMP_ENGINES-1:0] done_c;
        logic [`CMP_ENGINES-1:0] okay_c;
        cmp_record_u [`CMP_ENGINES-1:0] data_c;

        // gather this channel's column of engines
        for (genvar e = 0; e < `CMP_ENGINES; e++) begin : g_eng
            assign done_c[e]          = eng_cmp_done[e][c];
            assign data_c[e]          = eng_cmp_data[e][c];
            assign eng_cmp_okay[e][c] = okay_c[e];
        end

        cmp_channel_slot u_slot (
            .clk       (clk),
            .resetn    (resetn),
            .eng_done  (done_c),
            .eng_data  (data_c),
            .wr_accept (wr_accept[c]),
            .eng_okay  (okay_c),
            .pending   (slot_pending[c]),
            .record    (slot_record[c]),
            .irq_pulse (slot_irq_pulse[c])
        );
    end

    cmp_write_ctrl u_write_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .pending      (slot_pending),
        .records      (slot_record),
        .counts       (counts),
        .chan_cfg     (chan_cfg),
        .lcl_wr_ready (lcl_wr_ready),
        .lcl_wr_valid (lcl_wr_valid),
        .lcl_wr       (lcl_wr),
        .wr_accept    (wr_accept)
    );

    cmp_progress_tracker u_tracker (
        .clk             (clk),
        .resetn          (resetn),
        .manager_start   (manager_start),
        .channel_done    (channel_done),
        .wr_accept       (wr_accept),
        .chan_cfg        (chan_cfg),
        .counts          (counts),
        .completion_done (completion_done)
    );

    cmp_irq_merge u_irq_merge (
        .clk                  (clk),
        .resetn               (resetn),
        .irq_pulse            (slot_irq_pulse),
        .chan_cfg             (chan_cfg),
        .action_interrupt     (action_interrupt),
        .action_irq           (action_irq),
        .odma_interrupt_ack   (odma_interrupt_ack),
        .odma_interrupt       (odma_interrupt),
        .odma_irq             (odma_irq),
        .action_interrupt_ack (action_interrupt_ack)
    );

endmodule

`default_nettype wire

// ==== rtl/cmp_pkg.sv ====
/* completion manager types
   record, channel configuration, local write request and interrupt payload */
`default_nettype none
`include "cmp_settings.svh"

package cmp_pkg;

    // one record, stored raw and decoded for its interrupt flag
    typedef union packed {
        logic [`CMP_RECORD_W-1:0] raw;
        struct packed {
            logic [`CMP_RECORD_W-`CMP_IRQ_FLAG_BIT-2:0] hi;
            logic                                       irq_flag;
            logic [`CMP_IRQ_FLAG_BIT-1:0]               lo;
        } fields;
    } cmp_record_u;

    typedef struct packed {
        logic [`CMP_ADDR_W-1:0]   addr;
        logic [`CMP_HANDLE_W-1:0] obj_handle;
        logic [`CMP_COUNT_W-1:0]  last_id;
    } cmp_chan_cfg_t;

    typedef struct packed {
        logic [`CMP_ADDR_W-1:0]   addr;
        logic [`CMP_AXI_ID_W-1:0] axi_id;
        logic [`CMP_WRITE_W-1:0]  data;
    } cmp_write_req_t;

    typedef struct packed {
        logic [`CMP_CTX_W-1:0]    ctx;
        logic [`CMP_HANDLE_W-1:0] src;
    } cmp_irq_t;

    // fixed priority, lowest channel first
    function automatic logic [`CMP_CHAN_W-1:0] cmp_lowest_chan(
        input logic [`CMP_CHANNELS-1:0] req
    );
        logic [`CMP_CHAN_W-1:0] idx;
        idx = '0;
        for (int c = `CMP_CHANNELS - 1; c >= 0; c--) begin
            if (req[c]) begin
                idx = c[`CMP_CHAN_W-1:0];
            end
        end
        return idx;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/cmp_progress_tracker.sv ====
/* completion progress tracker
   counts accepted writes per channel and flags when a channel is complete */
`timescale 1ns/1ps
`default_nettype none
`include "cmp_settings.svh"

module cmp_progress_tracker (
    input  logic                                        clk,
    input  logic                                        resetn,
    input  logic                                        manager_start,
    input  logic [`CMP_CHANNELS-1:0]                    channel_done,
    input  logic [`CMP_CHANNELS-1:0]                    wr_accept,
    input  cmp_pkg::cmp_chan_cfg_t [`CMP_CHANNELS-1:0]  chan_cfg,
    output logic [`CMP_CHANNELS-1:0][`CMP_COUNT_W-1:0]  counts,
    output logic [`CMP_CHANNELS-1:0]                    completion_done
);
    localparam int CHANNELS = `CMP_CHANNELS;

    logic [CHANNELS-1:0] done_latch;

    // count starts at 1 so the first record carries 1
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            counts <= '0;
        end else begin
            for (int c = 0; c < CHANNELS; c++) begin
                if (manager_start) begin
                    counts[c] <= `CMP_COUNT_W'(1);
                end else if (wr_accept[c]) begin
                    counts[c] <= counts[c] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            done_latch <= '0;
        end else if (manager_start) begin
            done_latch <= '0;
        end else begin
            done_latch <= done_latch | channel_done;
        end
    end

    always_comb begin
        for (int c = 0; c < CHANNELS; c++) begin
            completion_done[c] = done_latch[c] & (counts[c] > chan_cfg[c].last_id);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cmp_settings.svh ====
/* completion manager settings
   channel and engine counts, widths, record layout and the write ID tag */
`ifndef CMP_SETTINGS_SVH
`define CMP_SETTINGS_SVH

`define CMP_CHANNELS      4
`define CMP_ENGINES       4
`define CMP_CHAN_W        2

`define CMP_RECORD_W      512
`define CMP_WRITE_W       1024
`define CMP_COUNT_W       30
// interrupt request flag inside a completion record
`define CMP_IRQ_FLAG_BIT  34

`define CMP_ADDR_W        64
`define CMP_HANDLE_W      64
`define CMP_CTX_W         9

`define CMP_ID_TAG        3'b101
`define CMP_AXI_ID_W      5

`endif

// ==== rtl/cmp_write_ctrl.sv ====
/* completion write controller
   picks a pending channel and posts its record and count as one local write */
`timescale 1ns/1ps
`default_nettype none
`include "cmp_settings.svh"

module cmp_write_ctrl (
    input  logic                                        clk,
    input  logic                                        resetn,
    input  logic [`CMP_CHANNELS-1:0]                    pending,
    input  cmp_pkg::cmp_record_u [`CMP_CHANNELS-1:0]    records,
    input  logic [`CMP_CHANNELS-1:0][`CMP_COUNT_W-1:0]  counts,
    input  cmp_pkg::cmp_chan_cfg_t [`CMP_CHANNELS-1:0]  chan_cfg,
    input  logic                                        lcl_wr_ready,
    output logic                                        lcl_wr_valid,
    output cmp_pkg::cmp_write_req_t                     lcl_wr,
    output logic [`CMP_CHANNELS-1:0]                    wr_accept
);
    import cmp_pkg::*;

    localparam int CHANNELS = `CMP_CHANNELS;
    localparam int PAD_W    = `CMP_WRITE_W - `CMP_RECORD_W - `CMP_COUNT_W;

    logic [`CMP_CHAN_W-1:0] wr_chan;
    logic                   wr_fire;

    assign wr_fire = lcl_wr_valid & lcl_wr_ready;

    // idle -> busy on any pending channel, busy -> idle on ready
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            lcl_wr_valid <= 1'b0;
            wr_chan      <= '0;
        end else if (!lcl_wr_valid) begin
            if (|pending) begin
                lcl_wr_valid <= 1'b1;
                wr_chan      <= cmp_lowest_chan(pending);
            end
        end else if (lcl_wr_ready) begin
            lcl_wr_valid <= 1'b0;
        end
    end

    // slot and count of the latched channel hold still until accept
    assign lcl_wr.addr   = chan_cfg[wr_chan].addr;
    assign lcl_wr.axi_id = {wr_chan, `CMP_ID_TAG};
    assign lcl_wr.data   = {records[wr_chan].raw, {PAD_W{1'b0}}, counts[wr_chan]};

    assign wr_accept = {{(CHANNELS-1){1'b0}}, wr_fire} << wr_chan;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the completion manager testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
    -f list.f \
    --top-module cmp_mgr_tb \
    -o cmp_mgr_sim

./obj_dir/cmp_mgr_sim

// ==== sim/cmp_mgr_props.sv ====
/* completion manager properties
   local write handshake and slot grant rules, bound into the top level */
`timescale 1ns/1ps
`default_nettype none
`include "cmp_settings.svh"

module cmp_mgr_props (
    input logic                                       clk,
    input logic                                       resetn,
    input logic [`CMP_ENGINES-1:0][`CMP_CHANNELS-1:0] eng_cmp_okay,
    input logic [`CMP_CHANNELS-1:0]                   slot_pending,
    input logic [`CMP_CHANNELS-1:0]                   wr_accept,
    input logic                                       lcl_wr_valid,
    input logic                                       lcl_wr_ready,
    input cmp_pkg::cmp_write_req_t                    lcl_wr
);
    logic [`CMP_CHANNELS-1:0] chan_okay;

    // any engine granted, per channel
    always_comb begin
        chan_okay = '0;
        for (int e = 0; e < `CMP_ENGINES; e++) begin
            chan_okay = chan_okay | eng_cmp_okay[e];
        end
    end

    a_wr_hold: assert property (@(posedge clk) disable iff (!resetn)
        lcl_wr_valid && !lcl_wr_ready |=> lcl_wr_valid && $stable(lcl_wr))
        else $error("local write changed or dropped before ready");

    a_okay_empty: assert property (@(posedge clk) disable iff (!resetn)
        (chan_okay & slot_pending) == '0)
        else $error("engine granted while its channel slot is full");

    a_accept_valid: assert property (@(posedge clk) disable iff (!resetn)
        (|wr_accept) |-> lcl_wr_valid)
        else $error("write accepted without a valid local write");

endmodule

bind cmp_mgr_top cmp_mgr_props u_props (
    .clk          (clk),
    .resetn       (resetn),
    .eng_cmp_okay (eng_cmp_okay),
    .slot_pending (slot_pending),
    .wr_accept    (wr_accept),
    .lcl_wr_valid (lcl_wr_valid),
    .lcl_wr_ready (lcl_wr_ready),
    .lcl_wr       (lcl_wr)
);

`default_nettype wire

// ==== sim/cmp_mgr_tests.svh ====
/* completion manager directed tests
   each task drives the DUT through one behaviour and checks the result */
`ifndef CMP_MGR_TESTS_SVH
`define CMP_MGR_TESTS_SVH

task automatic test_single_completion();
    cmp_record_u rec;
    int          e;
    int          c;
    e   = $urandom_range(3, 0);
    c   = $urandom_range(3, 0);
    rec = random_record(1'b0);
    start_manager();
    report(e, c, rec);
    // valid comes one edge after the record is stored
    check("lcl_wr_valid", chk_t'(lcl_wr_valid), chk_t'(0));
    @(negedge clk);
    check_write(c, rec, 1);
    accept_write();
endtask

task automatic test_back_pressure();
    cmp_record_u    rec_a;
    cmp_record_u    rec_b;
    cmp_write_req_t held;
    rec_a = random_record(1'b0);
    rec_b = random_record(1'b0);
    start_manager();
    report(0, 2, rec_a);
    wait_wr_valid();
    check_write(2, rec_a, 1);
    held = lcl_wr;
    // busy channel refuses a second report
    eng_cmp_done[3][2] = 1'b1;
    eng_cmp_data[3][2] = rec_b;
    repeat (4) begin
        #1;
        check("eng_cmp_okay", chk_t'(eng_cmp_okay), chk_t'(0));
        check("lcl_wr_valid", chk_t'(lcl_wr_valid), chk_t'(1'b1));
        check("lcl_wr.addr", chk_t'(lcl_wr.addr), chk_t'(held.addr));
        check("lcl_wr.data", chk_t'(lcl_wr.data), chk_t'(held.data));
        @(negedge clk);
    end
    accept_write();
    report(3, 2, rec_b);
    wait_wr_valid();
    check_write(2, rec_b, 2);
    accept_write();
endtask

task automatic test_priority();
    cmp_record_u rec_a;
    cmp_record_u rec_b;
    rec_a = random_record(1'b0);
    rec_b = random_record(1'b0);
    start_manager();
    // channels 1 and 3 in the same cycle
    eng_cmp_done[0][1] = 1'b1;
    eng_cmp_data[0][1] = rec_a;
    eng_cmp_done[2][3] = 1'b1;
    eng_cmp_data[2][3] = rec_b;
    #1;
    check("eng_cmp_okay", chk_t'(eng_cmp_okay), chk_t'(okay_bit(0, 1) | okay_bit(2, 3)));
    @(negedge clk);
    eng_cmp_done = '0;
    wait_wr_valid();
    check_write(1, rec_a, 1);
    accept_write();
    wait_wr_valid();
    check_write(3, rec_b, 1);
    accept_write();
    // engines 1 and 2 of channel 0 together
    rec_a = random_record(1'b0);
    rec_b = random_record(1'b0);
    eng_cmp_done[1][0] = 1'b1;
    eng_cmp_data[1][0] = rec_a;
    eng_cmp_done[2][0] = 1'b1;
    eng_cmp_data[2][0] = rec_b;
    #1;
    check("eng_cmp_okay", chk_t'(eng_cmp_okay), chk_t'(okay_bit(1, 0)));
    @(negedge clk);
    eng_cmp_done[1][0] = 1'b0;
    wait_wr_valid();
    check_write(0, rec_a, 1);
    accept_write();
    // slot empty again, waiting engine gets in
    report(2, 0, rec_b);
    wait_wr_valid();
    check_write(0, rec_b, 2);
    accept_write();
endtask

task automatic test_completion_done();
    cmp_record_u rec;
    chan_cfg[3].last_id = COUNT_W'(2);
    start_manager();
    channel_done = 4'b1000;
    @(negedge clk);
    channel_done = '0;
    for (int n = 1; n <= 2; n++) begin
        rec = random_record(1'b0);
        report(0, 3, rec);
        wait_wr_valid();
        check_write(3, rec, n);
        accept_write();
        check("completion_done", chk_t'(completion_done),
              chk_t'(n == 2 ? 4'b1000 : 4'b0000));
    end
    // restart clears the latch while the count still exceeds last id
    chan_cfg[3].last_id = '0;
    start_manager();
    check("completion_done", chk_t'(completion_done), chk_t'(0));
    chan_cfg[3].last_id = '1;
endtask

task automatic test_interrupts();
    cmp_record_u rec;
    cmp_irq_t    act;
    rec = random_record(1'b1);
    // action payload present but not requested
    act.ctx    = CTX_W'($urandom);
    act.src    = rand64();
    action_irq = act;
    start_manager();
    report(1, 2, rec);
    check("odma_interrupt", chk_t'(odma_interrupt), chk_t'(0));
    wait_odma_interrupt();
    check("odma_irq.ctx", chk_t'(odma_irq.ctx), chk_t'(0));
    check("odma_irq.src", chk_t'(odma_irq.src), chk_t'(chan_cfg[2].obj_handle));
    odma_interrupt_ack = 1'b1;
    #1;
    check("action_interrupt_ack", chk_t'(action_interrupt_ack), chk_t'(0));
    @(negedge clk);
    odma_interrupt_ack = 1'b0;
    check("odma_interrupt", chk_t'(odma_interrupt), chk_t'(0));
    // request is set once, no re-arm
    @(negedge clk);
    check("odma_interrupt", chk_t'(odma_interrupt), chk_t'(0));
    wait_wr_valid();
    check_write(2, rec, 1);
    accept_write();
    // action interrupt passes straight through
    action_interrupt = 1'b1;
    wait_odma_interrupt();
    check("odma_irq.ctx", chk_t'(odma_irq.ctx), chk_t'(act.ctx));
    check("odma_irq.src", chk_t'(odma_irq.src), chk_t'(act.src));
    odma_interrupt_ack = 1'b1;
    #1;
    check("action_interrupt_ack", chk_t'(action_interrupt_ack), chk_t'(1'b1));
    @(negedge clk);
    odma_interrupt_ack = 1'b0;
    action_interrupt   = 1'b0;
    check("odma_interrupt", chk_t'(odma_interrupt), chk_t'(0));
endtask

`endif

// ==== sim/cmp_mgr_tb.sv ====
/* completion manager testbench
   clock, reset, DUT and the directed test sequence */
`timescale 1ns/1ps
`default_nettype none
`include "cmp_settings.svh"

module cmp_mgr_tb;
    import cmp_pkg::*;

    localparam int WAIT_LIMIT = 50;
    localparam int COUNT_W    = `CMP_COUNT_W;
    localparam int CHAN_W     = `CMP_CHAN_W;
    localparam int CTX_W      = `CMP_CTX_W;
    localparam int PAD_W      = `CMP_WRITE_W - `CMP_RECORD_W - `CMP_COUNT_W;

    typedef logic [`CMP_WRITE_W-1:0] chk_t;
    typedef logic [`CMP_ENGINES-1:0][`CMP_CHANNELS-1:0] eng_bits_t;

    logic                                              clk;
    logic                                              resetn;
    eng_bits_t                                         eng_cmp_done;
    cmp_record_u [`CMP_ENGINES-1:0][`CMP_CHANNELS-1:0] eng_cmp_data;
    eng_bits_t                                         eng_cmp_okay;
    cmp_chan_cfg_t [`CMP_CHANNELS-1:0]                 chan_cfg;
    logic                                              manager_start;
    logic [`CMP_CHANNELS-1:0]                          channel_done;
    logic [`CMP_CHANNELS-1:0]                          completion_done;
    logic                                              lcl_wr_valid;
    cmp_write_req_t                                    lcl_wr;
    logic                                              lcl_wr_ready;
    logic                                              action_interrupt;
    cmp_irq_t                                          action_irq;
    logic                                              action_interrupt_ack;
    logic                                              odma_interrupt;
    cmp_irq_t                                          odma_irq;
    logic                                              odma_interrupt_ack;

    cmp_mgr_top dut_i (.*);

    always #10 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check(input string name, input chk_t got, input chk_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // poll on falling edges, bounded
    task automatic wait_wr_valid();
        int n;
        n = 0;
        while (!lcl_wr_valid) begin
            if (n == WAIT_LIMIT) begin
                stop_run("timeout: no local write was posted");
            end else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    task automatic wait_odma_interrupt();
        int n;
        n = 0;
        while (!odma_interrupt) begin
            if (n == WAIT_LIMIT) begin
                stop_run("timeout: host interrupt was never raised");
            end else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    function automatic cmp_record_u random_record(input logic flag);
        cmp_record_u rec;
        for (int w = 0; w < `CMP_RECORD_W / 32; w++) begin
            rec.raw[32*w +: 32] = $urandom;
        end
        rec.fields.irq_flag = flag;
        return rec;
    endfunction

    function automatic eng_bits_t okay_bit(input int e, input int c);
        eng_bits_t v;
        v = '0;
        v[e][c] = 1'b1;
        return v;
    endfunction

    // record on top, zero padding, count in the low bits
    function automatic chk_t expected_data(input cmp_record_u rec, input int count);
        return {rec.raw, {PAD_W{1'b0}}, COUNT_W'(count)};
    endfunction

    task automatic start_manager();
        manager_start = 1'b1;
        @(negedge clk);
        manager_start = 1'b0;
    endtask

    // engine holds done until okay, record stored at the next edge
    task automatic report(input int e, input int c, input cmp_record_u rec);
        eng_cmp_done[e][c] = 1'b1;
        eng_cmp_data[e][c] = rec;
        #1;
        check("eng_cmp_okay", chk_t'(eng_cmp_okay), chk_t'(okay_bit(e, c)));
        @(negedge clk);
        eng_cmp_done[e][c] = 1'b0;
    endtask

    task automatic check_write(input int c, input cmp_record_u rec, input int count);
        check("lcl_wr_valid", chk_t'(lcl_wr_valid), chk_t'(1'b1));
        check("lcl_wr.addr", chk_t'(lcl_wr.addr), chk_t'(chan_cfg[c].addr));
        check("lcl_wr.axi_id", chk_t'(lcl_wr.axi_id), chk_t'({CHAN_W'(c), 3'd5}));
        check("lcl_wr.data", chk_t'(lcl_wr.data), expected_data(rec, count));
    endtask

    task automatic accept_write();
        lcl_wr_ready = 1'b1;
        @(negedge clk);
        lcl_wr_ready = 1'b0;
        check("lcl_wr_valid", chk_t'(lcl_wr_valid), chk_t'(1'b0));
    endtask

    `include "cmp_mgr_tests.svh"

    initial begin
        void'($urandom(32'h4ea78dd3));
        clk                = 1'b0;
        resetn             = 1'b0;
        eng_cmp_done       = '0;
        eng_cmp_data       = '0;
        manager_start      = 1'b0;
        channel_done       = '0;
        lcl_wr_ready       = 1'b0;
        action_interrupt   = 1'b0;
        action_irq         = '0;
        odma_interrupt_ack = 1'b0;
        for (int c = 0; c < `CMP_CHANNELS; c++) begin
            chan_cfg[c].addr       = rand64();
            chan_cfg[c].obj_handle = rand64();
            chan_cfg[c].last_id    = '1;
        end
        repeat (4) @(negedge clk);
        resetn = 1'b1;
        check("lcl_wr_valid", chk_t'(lcl_wr_valid), chk_t'(0));
        check("eng_cmp_okay", chk_t'(eng_cmp_okay), chk_t'(0));
        check("odma_interrupt", chk_t'(odma_interrupt), chk_t'(0));
        check("action_interrupt_ack", chk_t'(action_interrupt_ack), chk_t'(0));
        check("completion_done", chk_t'(completion_done), chk_t'(0));

        test_single_completion();
        test_back_pressure();
        test_priority();
        test_completion_done();
        test_interrupts();

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
